// ==== basic_ptr_init.sv ====
// Walks the zero page after a PRG load and requests the BASIC pointer writes
`timescale 1ns/100ps

module basic_ptr_init (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        start_i,
	input  logic [15:0] end_addr_i,
	wr_req_if.producer  req,
	output logic        done_o
);
	import mem_pkg::*;
	import loader_pkg::*;

	logic [8:0] scan_addr;
	logic       busy;
	logic       req_valid;
	mem_byte_t  req_data;
	logic       hit;
	mem_byte_t  hit_data;

	// ==============================
	// Pointer table
	// ==============================

	always_comb begin
		hit      = 1'b1;
		hit_data = '0;
		case (scan_addr[7:0])
			// Text start keeps its reset value
			PTR_TXT_LO: hit_data = TXT_START[7:0];
			PTR_TXT_HI: hit_data = TXT_START[15:8];
			// Save start cleared as on reset
			PTR_SAVE, PTR_SAVE + 8'd1: hit_data = '0;
			// These all point at the first free byte after the program
			PTR_VAR, PTR_ARY, PTR_STR, PTR_LEND: hit_data = end_addr_i[7:0];
			PTR_VAR + 8'd1, PTR_ARY + 8'd1, PTR_STR + 8'd1, PTR_LEND + 8'd1: begin
				hit_data = end_addr_i[15:8];
			end
			default: hit = 1'b0;
		endcase
	end

	// ==============================
	// Scan sequencer
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy      <= 1'b0;
			req_valid <= 1'b0;
			done_o    <= 1'b0;
			scan_addr <= '0;
		end else begin
			done_o <= 1'b0;
			if (start_i && !busy) begin
				busy      <= 1'b1;
				scan_addr <= '0;
			end else if (busy) begin
				if (req_valid) begin
					// Hold the address until the request is taken
					if (req.ready) begin
						req_valid <= 1'b0;
						scan_addr <= scan_addr + 1'b1;
					end
				end else if (scan_addr == PTR_SCAN_END) begin
					busy   <= 1'b0;
					done_o <= 1'b1;
				end else if (hit) begin
					req_valid <= 1'b1;
				end else begin
					scan_addr <= scan_addr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (busy && !req_valid && hit) begin
			req_data <= hit_data;
		end
	end

	// Zero page address, stable while the request waits
	assign req.valid = req_valid;
	assign req.addr  = mem_addr_t'(scan_addr[7:0]);
	assign req.data  = req_data;

endmodule

// ==== load_cases.txt ====
# D <index> <byte count> <bytes...>   download record, all fields hex
# E <address> <byte>                  expected memory byte after the run, hex
D 04 6 00 C0 A9 01 8D 60
D 06 4 43 36 34 54
D 04 8 01 08 0B 08 0A 00 9E 00
E C000 A9
E C001 01
E C002 8D
E C003 60
E 200000 43
E 200001 36
E 200002 34
E 200003 54
E 0801 0B
E 0802 08
E 0803 0A
E 0804 00
E 0805 9E
E 0806 00
E 002B 01
E 002C 08
E 002D 07
E 002E 08
E 002F 07
E 0030 08
E 0031 07
E 0032 08
E 00AC 00
E 00AD 00
E 00AE 07
E 00AF 08

// ==== load_ctrl.sv ====
// Turns the host download strobes into write requests and starts pointer setup after a PRG
`timescale 1ns/100ps

module load_ctrl (
	input  logic               clk_sys,
	input  logic               reset_n,
	input  logic               dl_active_i,
	input  logic               dl_wr_i,
	input  logic [7:0]         dl_index_i,
	input  mem_pkg::mem_addr_t dl_addr_i,
	input  mem_pkg::mem_byte_t dl_data_i,
	output logic               dl_wait_o,
	wr_req_if.consumer         ptr_req,
	wr_req_if.producer         push,
	output logic               ptr_start_o,
	output logic [15:0]        ptr_end_o
);
	import mem_pkg::*;
	import loader_pkg::*;

	logic        load_prg;
	logic        load_tap;
	logic        is_hdr;
	logic        take_byte;
	logic        dl_active_q;
	logic        prg_mode;
	logic        dl_valid;
	mem_addr_t   load_addr;
	logic [15:0] end_addr;
	mem_req_t    dl_req;

	// ==============================
	// Index decode
	// ==============================

	assign load_prg  = (dl_index_i[7:6] == 2'b00) && (dl_index_i[5:0] == DL_IDX_PRG);
	assign load_tap  = (dl_index_i == DL_IDX_TAP);
	assign is_hdr    = (dl_addr_i < mem_addr_t'(PRG_HDR_LEN));

	// Bytes that become memory writes, PRG header excluded
	assign take_byte = dl_wr_i && ((load_prg && !is_hdr) || load_tap);

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dl_active_q <= 1'b0;
			prg_mode    <= 1'b0;
			dl_valid    <= 1'b0;
			ptr_start_o <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
			ptr_start_o <= 1'b0;
			// Remember the file type for the end of the download
			if (dl_active_i && !dl_active_q) begin
				prg_mode <= load_prg;
			end
			if (dl_active_q && !dl_active_i && prg_mode) begin
				ptr_start_o <= 1'b1;
			end
			if (take_byte) begin
				dl_valid <= 1'b1;
			end else if (push.ready) begin
				dl_valid <= 1'b0;
			end
		end
	end

	// ==============================
	// Addresses and payload
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i && load_prg) begin
			if (is_hdr) begin
				// Header gives the load address, low byte first
				load_addr[MEM_AW-1:16] <= '0;
				if (dl_addr_i[0]) begin
					load_addr[15:8] <= dl_data_i;
					end_addr[15:8]  <= dl_data_i;
				end else begin
					load_addr[7:0] <= dl_data_i;
					end_addr[7:0]  <= dl_data_i;
				end
			end else begin
				load_addr <= load_addr + 1'b1;
				end_addr  <= end_addr + 1'b1;
			end
		end
		if (take_byte) begin
			dl_req.addr <= load_tap ? (TAP_BASE + dl_addr_i) : load_addr;
			dl_req.data <= dl_data_i;
		end
	end

	// Download bytes first, pointer writes only once the last byte is queued
	assign push.valid    = dl_valid || ptr_req.valid;
	assign push.addr     = dl_valid ? dl_req.addr : ptr_req.addr;
	assign push.data     = dl_valid ? dl_req.data : ptr_req.data;
	assign ptr_req.ready = push.ready && !dl_valid;

	assign dl_wait_o = dl_valid;
	assign ptr_end_o = end_addr;

	// Host honours the wait level, otherwise a held byte would be overwritten
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		dl_wait_o |-> !dl_wr_i)
		else $error("load_ctrl: host write while a byte is still held");

endmodule

// ==== loader_pkg.sv ====
// Download format constants for PRG and TAP files and the BASIC zero-page pointer map
package loader_pkg;

	// ==============================
	// File index codes
	// ==============================

	// PRG matches on the low six bits, upper two bits must be clear
	localparam logic [5:0] DL_IDX_PRG = 6'd4;

	// TAP matches on the full index
	localparam logic [7:0] DL_IDX_TAP = 8'd6;

	// ==============================
	// File layout
	// ==============================

	// Load address, low byte first
	localparam int unsigned PRG_HDR_LEN = 2;

	// Tape images land in a fixed buffer above the main RAM
	localparam mem_pkg::mem_addr_t TAP_BASE = 25'h200000;

	// ==============================
	// BASIC pointers
	// ==============================

	// Scan covers the whole zero page
	localparam logic [8:0] PTR_SCAN_END = 9'h100;

	localparam logic [7:0] PTR_TXT_LO = 8'h2B;
	localparam logic [7:0] PTR_TXT_HI = 8'h2C;

	// Low bytes only, high byte sits one address up
	localparam logic [7:0] PTR_VAR  = 8'h2D;
	localparam logic [7:0] PTR_ARY  = 8'h2F;
	localparam logic [7:0] PTR_STR  = 8'h31;
	localparam logic [7:0] PTR_SAVE = 8'hAC;
	localparam logic [7:0] PTR_LEND = 8'hAE;

	// Reset value of the BASIC text start
	localparam logic [15:0] TXT_START = 16'h0801;

endpackage

// ==== mem_pkg.sv ====
// Memory-side types shared by the loader blocks; import where addresses or bytes are handled
package mem_pkg;

	// ==============================
	// Widths
	// ==============================

	// Byte address into the external SDRAM space
	parameter int unsigned MEM_AW = 25;

	// Memory is byte wide
	parameter int unsigned MEM_BW = 8;

	// ==============================
	// Types
	// ==============================

	typedef logic [MEM_AW-1:0] mem_addr_t;

	typedef logic [MEM_BW-1:0] mem_byte_t;

	// One pending memory write, address in the upper bits
	typedef struct packed {
		mem_addr_t addr;
		mem_byte_t data;
	} mem_req_t;

endpackage

// ==== mem_slot.sv ====
// Issues one queued memory write in each free bus slot, at the end of the slot level
`timescale 1ns/100ps

module mem_slot (
	input  logic               clk_sys,
	input  logic               reset_n,
	input  logic               io_cycle_i,
	wr_req_if.consumer         req,
	output logic               mem_we_o,
	output mem_pkg::mem_addr_t mem_addr_o,
	output mem_pkg::mem_byte_t mem_data_o
);
	import mem_pkg::*;

	logic     io_cycle_q;
	logic     slot_end;
	mem_req_t wr_q;

	// ==============================
	// Slot edge detect
	// ==============================

	// Falling edge of the slot level ends the free slot
	assign slot_end = io_cycle_q && !io_cycle_i;

	// Pop only at a slot end; without a request the slot goes unused
	assign req.ready = slot_end;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_q <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			mem_we_o   <= slot_end && req.valid;
		end
	end

	// ==============================
	// Write payload
	// ==============================

	// Captured in the same edge that raises the strobe
	always_ff @(posedge clk_sys) begin
		if (slot_end && req.valid) begin
			wr_q <= '{addr: req.addr, data: req.data};
		end
	end

	assign mem_addr_o = wr_q.addr;
	assign mem_data_o = wr_q.data;

	// One write per slot, so the strobe never lasts two cycles
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_we_o |=> !mem_we_o)
		else $error("mem_slot: write strobe held for two cycles");

endmodule

// ==== prg_loader_top.sv ====
// Download-to-memory loader top level, host strobes in and slot-timed memory writes out
`timescale 1ns/100ps

module prg_loader_top #(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  logic               clk_sys,
	input  logic               reset_n,
	// Host download stream
	input  logic               dl_active_i,
	input  logic               dl_wr_i,
	input  logic [7:0]         dl_index_i,
	input  mem_pkg::mem_addr_t dl_addr_i,
	input  mem_pkg::mem_byte_t dl_data_i,
	output logic               dl_wait_o,
	// System bus slot and memory write port
	input  logic               io_cycle_i,
	output logic               mem_we_o,
	output mem_pkg::mem_addr_t mem_addr_o,
	output mem_pkg::mem_byte_t mem_data_o,
	output logic               autostart_o
);

	wr_req_if ptr_req ();
	wr_req_if push_req ();
	wr_req_if pop_req ();

	logic        ctrl_wait;
	logic        fifo_full;
	logic        ptr_start;
	logic [15:0] ptr_end;

	// Host waits on a held byte or a full queue
	assign dl_wait_o = ctrl_wait || fifo_full;

	load_ctrl ctrl0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (ctrl_wait),
		.ptr_req     (ptr_req.consumer),
		.push        (push_req.producer),
		.ptr_start_o (ptr_start),
		.ptr_end_o   (ptr_end)
	);

	basic_ptr_init ptr0 (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.start_i    (ptr_start),
		.end_addr_i (ptr_end),
		.req        (ptr_req.producer),
		.done_o     (autostart_o)
	);

	req_fifo #(
		.DEPTH (FIFO_DEPTH)
	) fifo0 (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.push    (push_req.consumer),
		.pop     (pop_req.producer),
		.full_o  (fifo_full)
	);

	mem_slot slot0 (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.req        (pop_req.consumer),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

// ==== project.f ====
mem_pkg.sv
loader_pkg.sv
wr_req_if.sv
req_fifo.sv
mem_slot.sv
basic_ptr_init.sv
load_ctrl.sv
prg_loader_top.sv
tb_checker.sv
tb_top.sv

// ==== req_fifo.sv ====
// Small write-request queue between the download side and the bus slot issuer
`timescale 1ns/100ps

module req_fifo #(
	parameter int unsigned DEPTH = 4
) (
	input  logic       clk_sys,
	input  logic       reset_n,
	wr_req_if.consumer push,
	wr_req_if.producer pop,
	output logic       full_o
);
	import mem_pkg::*;

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	mem_req_t         q_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Wraps at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		nxt = ptr + 1'b1;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end
		return nxt;
	endfunction

	assign push.ready = (count != CNT_W'(DEPTH));
	assign do_push    = push.valid && push.ready;

	// Head of queue is visible the cycle after its push
	assign pop.valid = (count != '0);
	assign pop.addr  = q_mem[rd_ptr].addr;
	assign pop.data  = q_mem[rd_ptr].data;
	assign do_pop    = pop.valid && pop.ready;

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			q_mem[wr_ptr] <= '{addr: push.addr, data: push.data};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full_o <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Host wait level, one cycle behind the queue state
			full_o <= !push.ready;
		end
	end

	// Pointers meet only when the queue is empty or full, and the count never overflows
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		(count <= CNT_W'(DEPTH)) &&
		((wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH)))))
		else $error("req_fifo: count out of step with the pointers");

	// A stalled request must wait on the port unchanged
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		(push.valid && !push.ready) |=>
		(push.valid && $stable(push.addr) && $stable(push.data)))
		else $error("req_fifo: stalled request changed before acceptance");

endmodule

// ==== tb_checker.sv ====
// Testbench checker that records memory writes and autostart pulses and compares them
`timescale 1ns/100ps

module tb_checker (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        dl_active_i,
	input  logic        dl_wait_i,
	input  logic        mem_we_i,
	input  logic [24:0] mem_addr_i,
	input  logic [7:0]  mem_data_i,
	input  logic        autostart_i,
	output int          wr_count_o,
	output int          pulse_count_o
);

	logic [7:0]  mem_seen [logic [24:0]];
	logic [24:0] exp_addr [$];
	logic [7:0]  exp_data [$];
	int          wr_count    = 0;
	int          pulse_count = 0;
	int          err_value   = 0;
	int          err_missing = 0;
	int          err_other   = 0;
	int          wait_run    = 0;
	int          wait_max    = 0;
	logic        started     = 1'b0;
	logic        dl_seen     = 1'b0;

	assign wr_count_o    = wr_count;
	assign pulse_count_o = pulse_count;

	function automatic void expect_byte(input logic [24:0] addr, input logic [7:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endfunction

	// ==============================
	// Monitor
	// ==============================

	always @(posedge clk_sys) begin
		if (dl_active_i === 1'b1) begin
			dl_seen = 1'b1;
		end
		// Outputs stay quiet through reset and until the host starts
		if (started && !dl_seen && (mem_we_i !== 1'b0 || autostart_i !== 1'b0)) begin
			$display("Memory write or autostart seen before the first download at %0t", $time);
			err_other++;
		end
		if (reset_n && mem_we_i === 1'b1) begin
			mem_seen[mem_addr_i] = mem_data_i;
			wr_count++;
		end
		if (reset_n && autostart_i === 1'b1) begin
			pulse_count++;
		end
		if (dl_wait_i === 1'b1) begin
			wait_run++;
			if (wait_run > wait_max) begin
				wait_max = wait_run;
			end
		end else begin
			wait_run = 0;
		end
		started = 1'b1;
	end

	task automatic check_progress(input int n, input int exp_w, input int exp_p);
		if (wr_count != exp_w) begin
			$display("After download %0d there are %0d writes, expected %0d", n, wr_count, exp_w);
			err_other++;
		end
		if (pulse_count != exp_p) begin
			$display("After download %0d there are %0d autostart pulses, expected %0d",
				n, pulse_count, exp_p);
			err_other++;
		end
	endtask

	// ==============================
	// Final compare
	// ==============================

	task automatic final_check(input int exp_w, input int exp_p,
		output int n_value, output int n_missing, output int n_other);
		for (int i = 0; i < exp_addr.size(); i++) begin
			if (!mem_seen.exists(exp_addr[i])) begin
				$display("No write seen at address %h, expected byte %h", exp_addr[i], exp_data[i]);
				err_missing++;
			end else if (mem_seen[exp_addr[i]] !== exp_data[i]) begin
				$display("FAIL %0t: address %h expected %h actual %h",
					$time, exp_addr[i], exp_data[i], mem_seen[exp_addr[i]]);
				err_value++;
			end
		end
		if (wr_count != exp_w) begin
			$display("Saw %0d memory writes in total, expected %0d", wr_count, exp_w);
			err_other++;
		end
		if (pulse_count != exp_p) begin
			$display("Saw %0d autostart pulses in total, expected %0d", pulse_count, exp_p);
			err_other++;
		end
		if (wait_max < 2) begin
			$display("The wait level never held the host off for more than one cycle");
			err_other++;
		end
		n_value   = err_value;
		n_missing = err_missing;
		n_other   = err_other;
	endtask

endmodule

// ==== tb_top.sv ====
// Testbench top for the loader; reads load_cases.txt, drives downloads and bus slots, ends the run
`timescale 1ns/100ps

module tb_top;

	localparam int unsigned FIFO_DEPTH = 4;
	localparam int          HDR_LEN    = 2;
	// Text, VAR, ARY, STR, save start and load end, two bytes each
	localparam int          PTR_WRITES = 12;
	localparam logic [7:0]  IDX_PRG    = 8'h04;

	logic        clk_sys   = 1'b0;
	logic        reset_n   = 1'b0;
	logic        dl_active = 1'b0;
	logic        dl_wr     = 1'b0;
	logic [7:0]  dl_idx    = '0;
	logic [24:0] dl_addr   = '0;
	logic [7:0]  dl_data   = '0;
	logic        io_cycle  = 1'b0;
	logic        dl_wait;
	logic        mem_we;
	logic [24:0] mem_addr;
	logic [7:0]  mem_data;
	logic        autostart;

	int          wr_count;
	int          pulse_count;
	int unsigned cycle_count  = 0;
	int unsigned cycle_limit  = 0;
	int unsigned slot_gap     = 0;
	int          exp_writes   = 0;
	int          exp_pulses   = 0;
	int          write_target = 0;
	int          pulse_target = 0;

	// Download records, bytes kept in one flat queue
	logic [7:0]  dl_index [$];
	int          dl_first [$];
	int          dl_count [$];
	logic [7:0]  dl_bytes [$];

	always #5 clk_sys = ~clk_sys;

	prg_loader_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) dut0 (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active),
		.dl_wr_i     (dl_wr),
		.dl_index_i  (dl_idx),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.dl_wait_o   (dl_wait),
		.io_cycle_i  (io_cycle),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_data_o  (mem_data),
		.autostart_o (autostart)
	);

	tb_checker chk0 (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.dl_active_i   (dl_active),
		.dl_wait_i     (dl_wait),
		.mem_we_i      (mem_we),
		.mem_addr_i    (mem_addr),
		.mem_data_i    (mem_data),
		.autostart_i   (autostart),
		.wr_count_o    (wr_count),
		.pulse_count_o (pulse_count)
	);

	// Writes a download produces, pointer block only after a PRG
	function automatic int dl_writes(input logic [7:0] idx, input int cnt);
		return (idx == IDX_PRG) ? (cnt - HDR_LEN + PTR_WRITES) : cnt;
	endfunction

	// ==============================
	// Case file
	// ==============================

	function automatic logic read_cases();
		int          fd;
		int          code;
		int          cnt;
		int          k;
		logic [63:0] tok;
		logic [7:0]  ch;
		logic [7:0]  idx;
		logic [7:0]  b;
		logic [24:0] a;
		logic        ok;
		ok = 1'b1;
		fd = $fopen("load_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open load_cases.txt");
			return 1'b0;
		end
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			if (tok == "#") begin
				ch = 8'h00;
				while (ch != 8'h0a && !$feof(fd)) begin
					code = $fscanf(fd, "%c", ch);
				end
			end else if (tok == "D") begin
				code = $fscanf(fd, "%h %h", idx, cnt);
				dl_index.push_back(idx);
				dl_first.push_back(dl_bytes.size());
				dl_count.push_back(cnt);
				for (k = 0; k < cnt; k++) begin
					code = $fscanf(fd, "%h", b);
					dl_bytes.push_back(b);
				end
				exp_writes += dl_writes(idx, cnt);
				if (idx == IDX_PRG) begin
					exp_pulses++;
				end
			end else if (tok == "E") begin
				code = $fscanf(fd, "%h %h", a, b);
				chk0.expect_byte(a, b);
			end else begin
				$display("Unknown record type in load_cases.txt");
				ok = 1'b0;
			end
			code = $fscanf(fd, "%s", tok);
		end
		$fclose(fd);
		return ok;
	endfunction

	// ==============================
	// Stimulus
	// ==============================

	// Slot level high for one cycle, then low for a random gap
	always @(negedge clk_sys) begin
		if (!reset_n) begin
			io_cycle <= 1'b0;
			slot_gap <= 0;
		end else if (io_cycle) begin
			io_cycle <= 1'b0;
			slot_gap <= $urandom % 16;
		end else if (slot_gap == 0) begin
			io_cycle <= 1'b1;
		end else begin
			slot_gap <= slot_gap - 1;
		end
	end

	task automatic run_download(input int n);
		logic [7:0] idx;
		int         first;
		int         cnt;
		int         k;
		idx   = dl_index[n];
		first = dl_first[n];
		cnt   = dl_count[n];
		write_target += dl_writes(idx, cnt);
		if (idx == IDX_PRG) begin
			pulse_target++;
		end
		dl_idx    = idx;
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (k = 0; k < cnt; k++) begin
			while (dl_wait) begin
				@(negedge clk_sys);
			end
			dl_wr   = 1'b1;
			dl_addr = k;
			dl_data = dl_bytes[first + k];
			@(negedge clk_sys);
			dl_wr = 1'b0;
		end
		dl_active = 1'b0;
		// Queue drains and pointer setup runs at the pace of the slots
		while (wr_count < write_target) begin
			@(negedge clk_sys);
		end
		while (pulse_count < pulse_target) begin
			@(negedge clk_sys);
		end
		repeat (10) @(negedge clk_sys);
		chk0.check_progress(n, write_target, pulse_target);
	endtask

	task automatic finish_run(input logic abort);
		int n_value;
		int n_missing;
		int n_other;
		int total;
		chk0.final_check(exp_writes, exp_pulses, n_value, n_missing, n_other);
		if (abort) begin
			n_other++;
		end
		total = n_value + n_missing + n_other;
		$display("Errors: %0d total, %0d value, %0d missing, %0d other",
			total, n_value, n_missing, n_other);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// Run limit grows with the number of bytes and downloads
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout, run did not complete within %0d cycles", cycle_limit);
			finish_run(1'b1);
		end
	end

	initial begin
		void'($urandom(32'h4e7e6216));
		if (!read_cases()) begin
			$display("Case file could not be used, run stopped");
			finish_run(1'b1);
		end else begin
			cycle_limit = 200 * dl_bytes.size() + 2000 * dl_index.size();
			repeat (5) @(posedge clk_sys);
			@(negedge clk_sys);
			reset_n = 1'b1;
			repeat (10) @(negedge clk_sys);
			for (int n = 0; n < dl_index.size(); n++) begin
				run_download(n);
			end
			finish_run(1'b0);
		end
	end

endmodule

// ==== wr_req_if.sv ====
// Valid/ready bundle for one memory write request between loader blocks
`timescale 1ns/100ps

interface wr_req_if;

	logic               valid;
	logic               ready;
	mem_pkg::mem_addr_t addr;
	mem_pkg::mem_byte_t data;

	// Producer holds addr and data while valid is high and ready is low
	modport producer (
		output valid,
		output addr,
		output data,
		input  ready
	);

	modport consumer (
		input  valid,
		input  addr,
		input  data,
		output ready
	);

endinterface
